// File: hw/afifo_pkg.sv
/*
 * Asynchronous FIFO shared constants and types
 * Depth, word width and clock-crossing length used by every block
 */

package afifo_pkg;

	////////////////////////////////////////////////////////////
	// Sizing
	////////////////////////////////////////////////////////////

	// Log2 of the number of storage entries
	localparam int FIFO_AW = 3;

	// Storage entries, 8 for the current address width
	localparam int FIFO_DEPTH = 1 << FIFO_AW;

	// Bits per FIFO word
	localparam int DATA_W = 16;

	// Flops in each clock-crossing chain, two at least
	localparam int SYNC_STAGES = 2;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// One FIFO word
	typedef logic [DATA_W-1:0] data_t;

	// Storage index
	typedef logic [FIFO_AW-1:0] addr_t;

	// Pointer with one wrap bit above the address
	// Holds either the binary or the Gray form
	typedef logic [FIFO_AW:0] ptr_t;

endpackage

// File: hw/afifo_mem.sv
/*
 * Asynchronous FIFO storage
 * Dual-port array, written on the write clock, read by address
 */

`timescale 1ns/1ps

module afifo_mem (
	input  logic               i_wr_clk,
	input  logic               i_wr_en,
	input  afifo_pkg::addr_t   i_wr_addr,
	input  afifo_pkg::data_t   i_wr_data,
	input  afifo_pkg::addr_t   i_rd_addr,
	output afifo_pkg::data_t   o_rd_data
);

	// Storage array, contents undefined until written
	afifo_pkg::data_t mem [afifo_pkg::FIFO_DEPTH];

	// Write port
	// Word lands one write clock after the enable
	always_ff @(posedge i_wr_clk)
	begin
		if (i_wr_en)
		begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// Read port, no clock
	// The read side registers this word in its output stage
	assign o_rd_data = mem[i_rd_addr];

endmodule

// File: hw/afifo_gray_sync.sv
/*
 * Gray pointer synchronizer
 * Carries a Gray pointer into the destination clock domain
 */

`timescale 1ns/1ps

module afifo_gray_sync (
	input  logic               gbl_clk,
	input  logic               i_rd_reset_n,
	input  afifo_pkg::ptr_t    i_gray,
	output afifo_pkg::ptr_t    o_gray
);

	// Crossing chain, stage 0 samples the foreign pointer
	(* ASYNC_REG = "TRUE" *) afifo_pkg::ptr_t sync_q [afifo_pkg::SYNC_STAGES];

	// Decoded output, only used by the check below
	afifo_pkg::ptr_t out_bin;

	// Gray to binary, each bit folds in everything above it
	function automatic afifo_pkg::ptr_t gray2bin(input afifo_pkg::ptr_t g);
		afifo_pkg::ptr_t b;
		b[afifo_pkg::FIFO_AW] = g[afifo_pkg::FIFO_AW];
		for (int i = afifo_pkg::FIFO_AW - 1; i >= 0; i--)
		begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	// Shift chain
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			for (int i = 0; i < afifo_pkg::SYNC_STAGES; i++)
			begin
				sync_q[i] <= '0;
			end
		end
		else
		begin
			sync_q[0] <= i_gray;
			for (int i = 1; i < afifo_pkg::SYNC_STAGES; i++)
			begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// Last stage is the settled pointer
	assign o_gray = sync_q[afifo_pkg::SYNC_STAGES-1];

	assign out_bin = gray2bin(o_gray);

	// Synchronized pointer only moves forward, never by more than the depth
	// A faster source may step more than once between two samples
	a_sync_forward: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		afifo_pkg::ptr_t'(out_bin - $past(out_bin)) <= afifo_pkg::FIFO_DEPTH);

endmodule

// File: hw/afifo_wr_ptr.sv
/*
 * Asynchronous FIFO write side
 * Binary and Gray write pointers, full flag and storage write enable
 */

`timescale 1ns/1ps

module afifo_wr_ptr (
	input  logic               i_wr_clk,
	input  logic               i_wr_reset_n,
	input  logic               i_wr,
	input  afifo_pkg::ptr_t    i_rgray_sync,
	output logic               o_wr_full,
	output logic               o_wr_en,
	output afifo_pkg::addr_t   o_wr_addr,
	output afifo_pkg::ptr_t    o_wgray
);

	localparam int MSB = afifo_pkg::FIFO_AW;

	// Binary pointer addresses storage
	afifo_pkg::ptr_t wr_bin;
	// Gray copy crosses to the read domain
	afifo_pkg::ptr_t wgray;
	afifo_pkg::ptr_t wr_bin_next;
	logic            wr_accept;

	////////////////////////////////////////////////////////////
	// Accept and advance
	////////////////////////////////////////////////////////////

	// Write taken only while not full
	assign wr_accept   = i_wr && !o_wr_full;
	assign wr_bin_next = wr_bin + 1'b1;

	always_ff @(posedge i_wr_clk or negedge i_wr_reset_n)
	begin
		if (!i_wr_reset_n)
		begin
			wr_bin <= '0;
			wgray  <= '0;
		end
		else if (wr_accept)
		begin
			wr_bin <= wr_bin_next;
			// Gray copy registered, so the crossing sees clean edges
			wgray  <= wr_bin_next ^ (wr_bin_next >> 1);
		end
	end

	////////////////////////////////////////////////////////////
	// Full flag
	////////////////////////////////////////////////////////////

	// Full when the read pointer is one lap behind
	// In Gray form a lap flips the top two bits
	assign o_wr_full = (i_rgray_sync == {~wgray[MSB:MSB-1], wgray[MSB-2:0]});

	// Storage port
	assign o_wr_en   = wr_accept;
	assign o_wr_addr = wr_bin[afifo_pkg::FIFO_AW-1:0];
	assign o_wgray   = wgray;

	// Gray pointer flips one bit at most per write clock
	a_wgray_one_bit: assert property (@(posedge i_wr_clk) disable iff (!i_wr_reset_n)
		$countones(wgray ^ $past(wgray)) <= 1);

	// No advance while full, so storage is never overrun
	a_no_wr_when_full: assert property (@(posedge i_wr_clk) disable iff (!i_wr_reset_n)
		o_wr_full |=> $stable(wr_bin));

endmodule

// File: hw/afifo_rd_ptr.sv
/*
 * Asynchronous FIFO read side
 * Read pointers, store-empty test and the registered output stage
 */

`timescale 1ns/1ps

module afifo_rd_ptr (
	input  logic               gbl_clk,
	input  logic               i_rd_reset_n,
	input  logic               i_rd,
	input  afifo_pkg::ptr_t    i_wgray_sync,
	input  afifo_pkg::data_t   i_mem_data,
	output afifo_pkg::addr_t   o_rd_addr,
	output afifo_pkg::ptr_t    o_rgray,
	output afifo_pkg::data_t   o_rd_data,
	output logic               o_rd_empty
);

	// Binary pointer addresses storage
	afifo_pkg::ptr_t rd_bin;
	// Gray copy crosses to the write domain
	afifo_pkg::ptr_t rgray;
	afifo_pkg::ptr_t rd_bin_next;
	// Nothing in storage beyond what the output stage holds
	logic            store_empty;
	// Output stage takes a new value this edge
	logic            out_load;
	// Load pulls a real word, so the pointer moves
	logic            rd_advance;

	////////////////////////////////////////////////////////////
	// Store-empty and load control
	////////////////////////////////////////////////////////////

	// Equal Gray pointers, all written words already taken
	assign store_empty = (i_wgray_sync == rgray);

	// Stage refills when empty or when its word is consumed
	assign out_load    = o_rd_empty || i_rd;
	assign rd_advance  = out_load && !store_empty;
	assign rd_bin_next = rd_bin + 1'b1;

	// Pointer pair
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			rd_bin <= '0;
			rgray  <= '0;
		end
		else if (rd_advance)
		begin
			rd_bin <= rd_bin_next;
			rgray  <= rd_bin_next ^ (rd_bin_next >> 1);
		end
	end

	////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////

	// Empty flag of the stage, follows store-empty on each load
	always_ff @(posedge gbl_clk or negedge i_rd_reset_n)
	begin
		if (!i_rd_reset_n)
		begin
			o_rd_empty <= 1'b1;
		end
		else if (out_load)
		begin
			o_rd_empty <= store_empty;
		end
	end

	// Data word, meaningful only while the stage is not empty
	always_ff @(posedge gbl_clk)
	begin
		if (out_load)
		begin
			o_rd_data <= i_mem_data;
		end
	end

	assign o_rd_addr = rd_bin[afifo_pkg::FIFO_AW-1:0];
	assign o_rgray   = rgray;

	// Head word holds while the reader stalls
	a_rd_hold: assert property (@(posedge gbl_clk) disable iff (!i_rd_reset_n)
		(!o_rd_empty && !i_rd) |=> ($stable(o_rd_data) && !o_rd_empty));

endmodule

// File: hw/afifo_top.sv
/*
 * Asynchronous FIFO top level
 * Storage, both pointer blocks and the two Gray crossings
 */

`timescale 1ns/1ps

module afifo_top (
	// Write domain
	input  logic               i_wr_clk,
	input  logic               i_wr_reset_n,
	input  logic               i_wr,
	input  afifo_pkg::data_t   i_wr_data,
	output logic               o_wr_full,
	// Read domain
	input  logic               gbl_clk,
	input  logic               i_rd_reset_n,
	input  logic               i_rd,
	output afifo_pkg::data_t   o_rd_data,
	output logic               o_rd_empty
);

	// Storage port signals
	logic             wr_en;
	afifo_pkg::addr_t wr_addr;
	afifo_pkg::addr_t rd_addr;
	afifo_pkg::data_t mem_data;

	// Gray pointers, local and crossed
	afifo_pkg::ptr_t  wgray;
	afifo_pkg::ptr_t  rgray;
	afifo_pkg::ptr_t  wgray_sync;
	afifo_pkg::ptr_t  rgray_sync;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	afifo_mem u_mem (
		.i_wr_clk  (i_wr_clk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (i_wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (mem_data)
	);

	////////////////////////////////////////////////////////////
	// Write side and its view of the read pointer
	////////////////////////////////////////////////////////////

	afifo_wr_ptr u_wr_ptr (
		.i_wr_clk     (i_wr_clk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_rgray_sync (rgray_sync),
		.o_wr_full    (o_wr_full),
		.o_wr_en      (wr_en),
		.o_wr_addr    (wr_addr),
		.o_wgray      (wgray)
	);

	// Read pointer into the write clock domain
	afifo_gray_sync u_rgray_to_wr (
		.gbl_clk      (i_wr_clk),
		.i_rd_reset_n (i_wr_reset_n),
		.i_gray       (rgray),
		.o_gray       (rgray_sync)
	);

	////////////////////////////////////////////////////////////
	// Read side and its view of the write pointer
	////////////////////////////////////////////////////////////

	afifo_rd_ptr u_rd_ptr (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.i_wgray_sync (wgray_sync),
		.i_mem_data   (mem_data),
		.o_rd_addr    (rd_addr),
		.o_rgray      (rgray),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

	// Write pointer into the read clock domain
	afifo_gray_sync u_wgray_to_rd (
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_gray       (wgray),
		.o_gray       (wgray_sync)
	);

endmodule

// File: test/tb_afifo.sv
/*
 * Asynchronous FIFO testbench
 * Fill, drain, hold and random traffic against a queue model
 */

`timescale 1ns/1ps

module tb_afifo;

	localparam int SLOW_PERIOD_NS = 100;
	localparam logic [31:0] LFSR_SEED = 32'h3a59_b1c2;
	// Phase lengths in cycles of the slower clock
	localparam int RESET_CYCLES = 3;
	localparam int IDLE_CYCLES = 5;
	localparam int FILL_CYCLES = 40;
	localparam int DRAIN_CYCLES = 40;
	localparam int RANDOM_CYCLES = 400;
	localparam int LAST_DRAIN_CYCLES = 60;
	localparam int MARGIN_CYCLES = 200;
	localparam int RUN_CYCLES = RESET_CYCLES + IDLE_CYCLES + FILL_CYCLES + DRAIN_CYCLES
		+ RANDOM_CYCLES + LAST_DRAIN_CYCLES + MARGIN_CYCLES;

	logic             gbl_clk = 1'b0;
	logic             i_wr_clk = 1'b0;
	logic             i_rd_reset_n = 1'b0;
	logic             i_wr_reset_n = 1'b0;
	logic             i_wr = 1'b0;
	logic             i_rd = 1'b0;
	afifo_pkg::data_t i_wr_data = '0;
	afifo_pkg::data_t o_rd_data;
	logic             o_wr_full;
	logic             o_rd_empty;

	// Words accepted by the DUT and not yet read
	afifo_pkg::data_t model_q [$];
	logic [31:0] wr_lfsr = LFSR_SEED;
	logic [31:0] rd_lfsr = LFSR_SEED;
	int value_errors = 0;
	int other_errors = 0;
	int accepted = 0;
	int reads = 0;
	int hold_checks = 0;
	logic hold_armed = 1'b0;
	logic wr_done = 1'b0;
	afifo_pkg::data_t held_data;

	afifo_top i_dut (
		.i_wr_clk     (i_wr_clk),
		.i_wr_reset_n (i_wr_reset_n),
		.i_wr         (i_wr),
		.i_wr_data    (i_wr_data),
		.o_wr_full    (o_wr_full),
		.gbl_clk      (gbl_clk),
		.i_rd_reset_n (i_rd_reset_n),
		.i_rd         (i_rd),
		.o_rd_data    (o_rd_data),
		.o_rd_empty   (o_rd_empty)
	);

	// Read clock at 100 ns and write clock at 70 ns so the phases drift
	always #50 gbl_clk = ~gbl_clk;
	always #35 i_wr_clk = ~i_wr_clk;

	////////////////////////////////////////////////////////////
	// Random source, model and checks
	////////////////////////////////////////////////////////////

	// Galois LFSR shifting right with maximal-length taps
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic draw_bits(inout logic [31:0] state, input int nbits,
		output logic [15:0] bits);
		bits = '0;
		for (int i = 0; i < nbits; i++)
		begin
			state = lfsr_next(state);
			bits[i] = state[0];
		end
	endtask

	// Head of the model is the oldest accepted word
	function automatic afifo_pkg::data_t expected_head();
		return model_q.pop_front();
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	// One write clock with the accept seen at the rising edge
	task automatic write_cycle(input logic force_wr);
		logic [15:0] wr_bit;
		logic [15:0] word;
		wr_bit = 16'h1;
		if (!force_wr)
		begin
			draw_bits(wr_lfsr, 1, wr_bit);
		end
		draw_bits(wr_lfsr, 16, word);
		@(negedge i_wr_clk);
		i_wr = wr_bit[0];
		i_wr_data = word;
		@(posedge i_wr_clk);
		if (i_wr && !o_wr_full)
		begin
			model_q.push_back(word);
			accepted++;
		end
	endtask

	// Read until empty has held for 10 read clocks
	task automatic drain_reader();
		int empty_run;
		empty_run = 0;
		while (empty_run < 10)
		begin
			@(negedge gbl_clk);
			i_rd = 1'b1;
			@(posedge gbl_clk);
			empty_run = o_rd_empty ? empty_run + 1 : 0;
		end
		@(negedge gbl_clk);
		i_rd = 1'b0;
	endtask

	// Compare process that also checks the head holds while the reader stalls
	always @(posedge gbl_clk)
	begin
		if (i_rd_reset_n)
		begin
			if (hold_armed)
			begin
				check_value("o_rd_data", o_rd_data, held_data);
				hold_checks++;
			end
			hold_armed = !o_rd_empty && !i_rd;
			held_data = o_rd_data;
			if (!o_rd_empty && i_rd)
			begin
				reads++;
				if (model_q.size() == 0)
					report_failure("word read while the model holds nothing");
				else
					check_value("o_rd_data", o_rd_data, expected_head());
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int full_run;
		repeat (RESET_CYCLES) @(posedge gbl_clk);
		@(negedge gbl_clk);
		i_rd_reset_n = 1'b1;
		@(negedge i_wr_clk);
		i_wr_reset_n = 1'b1;

		// Idle after reset with no write yet
		repeat (IDLE_CYCLES)
		begin
			@(posedge gbl_clk);
			check_value("o_rd_empty", 32'(o_rd_empty), 32'd1);
			check_value("o_wr_full", 32'(o_wr_full), 32'd0);
		end

		// Fill with the reader idle until 8 sit in storage and 1 in the output stage
		full_run = 0;
		while (full_run < 10)
		begin
			write_cycle(1'b1);
			full_run = o_wr_full ? full_run + 1 : 0;
		end
		@(negedge i_wr_clk);
		i_wr = 1'b0;
		check_value("accepted words", 32'(accepted), 32'd9);

		// Drain with words leaving in write order
		drain_reader();
		check_value("words read", 32'(reads), 32'd9);
		check_value("model queue size", 32'(model_q.size()), 32'd0);
		check_value("o_wr_full", 32'(o_wr_full), 32'd0);

		// Random traffic on both sides
		fork
			begin
				for (int n = 0; n < RANDOM_CYCLES; n++)
				begin
					write_cycle(1'b0);
				end
				@(negedge i_wr_clk);
				i_wr = 1'b0;
				wr_done = 1'b1;
			end
			begin
				logic [15:0] rd_bit;
				while (!wr_done)
				begin
					draw_bits(rd_lfsr, 1, rd_bit);
					@(negedge gbl_clk);
					i_rd = rd_bit[0];
				end
				drain_reader();
			end
		join
		check_value("model queue size", 32'(model_q.size()), 32'd0);
		if (hold_checks == 0)
			report_failure("output stage was never held by a stalled reader");

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog sized from the phase lengths at the slower period
	initial
	begin
		#(RUN_CYCLES * SLOW_PERIOD_NS);
		$display("Timeout: the test sequence did not complete in time");
		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: filelist.f
hw/afifo_pkg.sv
hw/afifo_mem.sv
hw/afifo_gray_sync.sv
hw/afifo_wr_ptr.sv
hw/afifo_rd_ptr.sv
hw/afifo_top.sv
test/tb_afifo.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the asynchronous FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_afifo \
	--Mdir obj_dir \
	-o sim_afifo \
	-f filelist.f

./obj_dir/sim_afifo | tee "$LOG"

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
